// ==== rtl/uart_pkg.sv ====
package uart_pkg;

    // character format, 8N1 only
    localparam int DATA_W = 8;                  // bits per character
    localparam int BIT_IDX_W = $clog2(DATA_W);  // width of the data bit index

    // index of the last data bit, sized to match the bit counters in both engines
    localparam logic [BIT_IDX_W-1:0] LAST_BIT = BIT_IDX_W'(DATA_W - 1);

    // byte queues
    localparam int FIFO_DEPTH = 16;  // entries per direction
    localparam int FIFO_AW = 4;      // pointer width, count is one bit wider

    // count value at which a queue reports full
    localparam logic [FIFO_AW:0] FIFO_FULL_CNT = (FIFO_AW + 1)'(FIFO_DEPTH);

    // runtime baud divisor, clock cycles per bit
    localparam int DIV_W = 16;

    // transmit serializer
    typedef enum logic [1:0] {
        TX_IDLE,   // line high, waiting for a queued byte
        TX_START,  // start bit, line low
        TX_DATA,   // data bits, lsb first
        TX_STOP    // stop bit, line high
    } tx_state_t;

    // receive deserializer
    typedef enum logic [1:0] {
        RX_IDLE,   // watching for a falling edge
        RX_START,  // start bit, re-checked at mid-bit
        RX_DATA,   // sampling data bits at mid-bit
        RX_STOP    // stop bit sample decides push or framing error
    } rx_state_t;

endpackage

// ==== rtl/baud_if.sv ====
interface baud_if;

    logic [uart_pkg::DIV_W-1:0] baud_div;  // cycles per bit, from the top
    logic                       restart;   // engine holds the timer at zero while high
    logic                       tick_mid;  // one-cycle pulse at the middle of a bit
    logic                       tick_end;  // one-cycle pulse on the last cycle of a bit

    modport timer (
        input  baud_div,
        input  restart,
        output tick_mid,
        output tick_end
    );

    modport engine (
        input  baud_div,
        output restart,
        input  tick_mid,
        input  tick_end
    );

endinterface

// ==== rtl/baud_timer.sv ====
module baud_timer (
    input  logic clk,
    input  logic rst_n,
    baud_if.timer bif
);

    logic [uart_pkg::DIV_W-1:0] count;     // position inside the current bit
    logic [uart_pkg::DIV_W-1:0] mid_point; // half of the divisor
    logic [uart_pkg::DIV_W-1:0] last_cnt;  // divisor minus one
    logic                       at_last;

    assign mid_point = bif.baud_div >> 1;
    assign last_cnt = bif.baud_div - 1'b1;
    assign at_last = (count == last_cnt);

    // count runs 0 .. baud_div-1 and wraps, held at zero during restart
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (bif.restart) begin
            count <= '0; // engine idle, keep phase aligned for the next bit
        end else if (at_last) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // ticks are decoded from the count, both suppressed while held
    assign bif.tick_mid = !bif.restart && (count == mid_point);
    assign bif.tick_end = !bif.restart && at_last;

endmodule

// ==== rtl/byte_fifo.sv ====
module byte_fifo (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        push,
    input  logic [uart_pkg::DATA_W-1:0] wr_data,
    input  logic                        pop,
    output logic [uart_pkg::DATA_W-1:0] rd_data,
    output logic                        full,
    output logic                        empty
);

    logic [uart_pkg::DATA_W-1:0] mem [uart_pkg::FIFO_DEPTH];

    logic [uart_pkg::FIFO_AW-1:0] wr_ptr;
    logic [uart_pkg::FIFO_AW-1:0] rd_ptr;
    logic [uart_pkg::FIFO_AW:0]   count;   // one bit wider so full is distinct from empty

    logic do_push;
    logic do_pop;

    assign full = (count == uart_pkg::FIFO_FULL_CNT);
    assign empty = (count == '0);

    // blocked requests are simply dropped
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    // head entry read straight out of the array
    assign rd_data = mem[rd_ptr];

    // storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // pointers wrap at the depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // both or neither, level unchanged
            endcase
        end
    end

endmodule

// ==== rtl/uart_tx_fsm.sv ====
module uart_tx_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        empty,
    input  logic [uart_pkg::DATA_W-1:0] rd_data,
    output logic                        pop,
    output logic                        tx_pin,
    baud_if.engine bif
);

    uart_pkg::tx_state_t state;

    logic [uart_pkg::DATA_W-1:0]    shift_q;  // byte being sent, lsb goes out first
    logic [uart_pkg::BIT_IDX_W-1:0] bit_idx;  // data bit currently on the line

    // take a byte only between frames
    assign pop = (state == uart_pkg::TX_IDLE) && !empty;

    // bit timer runs for the whole frame, held while idle
    assign bif.restart = (state == uart_pkg::TX_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= uart_pkg::TX_IDLE;
            bit_idx <= '0;
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    bit_idx <= '0;
                    if (pop) begin
                        state <= uart_pkg::TX_START;  // line drops on the next cycle
                    end
                end
                uart_pkg::TX_START: begin
                    if (bif.tick_end) begin
                        state <= uart_pkg::TX_DATA;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bif.tick_end) begin
                        if (bit_idx == uart_pkg::LAST_BIT) begin
                            state <= uart_pkg::TX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    // back to idle, a waiting byte is popped right away
                    if (bif.tick_end) begin
                        state <= uart_pkg::TX_IDLE;
                    end
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    // shift register, loaded on pop and shifted after each data bit
    always_ff @(posedge clk) begin
        if (pop) begin
            shift_q <= rd_data;
        end else if (state == uart_pkg::TX_DATA && bif.tick_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    // line level decoded from the state
    always_comb begin
        case (state)
            uart_pkg::TX_START: tx_pin = 1'b0;        // start bit
            uart_pkg::TX_DATA:  tx_pin = shift_q[0];
            default:            tx_pin = 1'b1;        // idle and stop are marking
        endcase
    end

endmodule

// ==== rtl/uart_rx_fsm.sv ====
module uart_rx_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rx_pin,
    output logic                        push,
    output logic [uart_pkg::DATA_W-1:0] wr_data,
    output logic                        frame_error,
    baud_if.engine bif
);

    uart_pkg::rx_state_t state;

    logic [1:0] rx_sync;  // two-flop synchronizer, [1] is the safe copy
    logic       rx_s;     // synchronized line
    logic       rx_prev;  // previous synchronized level for edge detect
    logic       fall;

    logic [uart_pkg::DATA_W-1:0]    shift_q;  // bits arrive lsb first from the top end
    logic [uart_pkg::BIT_IDX_W-1:0] bit_idx;

    assign rx_s = rx_sync[1];
    assign fall = rx_prev && !rx_s;

    // line idles high, so reset the synchronizer to marking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], rx_pin};
            rx_prev <= rx_s;
        end
    end

    // timer released only once a start edge was seen
    assign bif.restart = (state == uart_pkg::RX_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= uart_pkg::RX_IDLE;
            bit_idx <= '0;
        end else begin
            case (state)
                uart_pkg::RX_IDLE: begin
                    bit_idx <= '0;
                    if (fall) begin
                        state <= uart_pkg::RX_START;  // bit period starts from the edge
                    end
                end
                uart_pkg::RX_START: begin
                    if (bif.tick_mid && rx_s) begin
                        state <= uart_pkg::RX_IDLE;  // high at mid-bit, only a glitch
                    end else if (bif.tick_end) begin
                        state <= uart_pkg::RX_DATA;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (bif.tick_end) begin
                        if (bit_idx == uart_pkg::LAST_BIT) begin
                            state <= uart_pkg::RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                uart_pkg::RX_STOP: begin
                    // leave at mid stop so the next start edge is not missed
                    if (bif.tick_mid) begin
                        state <= uart_pkg::RX_IDLE;
                    end
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    // deserializer, sample each data bit at mid-bit
    always_ff @(posedge clk) begin
        if (state == uart_pkg::RX_DATA && bif.tick_mid) begin
            shift_q <= {rx_s, shift_q[uart_pkg::DATA_W-1:1]};
        end
    end

    assign wr_data = shift_q;

    // stop sample decides the outcome, both are single-cycle pulses
    assign push = (state == uart_pkg::RX_STOP) && bif.tick_mid && rx_s;
    assign frame_error = (state == uart_pkg::RX_STOP) && bif.tick_mid && !rx_s;

endmodule

// ==== rtl/uart_top.sv ====
module uart_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [uart_pkg::DIV_W-1:0]  baud_div,        // cycles per bit, at least 4
    input  logic                        tx_write,        // single-cycle write strobe
    input  logic [uart_pkg::DATA_W-1:0] tx_data,
    output logic                        tx_pin,
    output logic                        tx_full,
    output logic                        tx_empty,
    input  logic                        rx_pin,
    input  logic                        rx_read,         // pops the head when not empty
    output logic                        rx_ready,
    output logic [uart_pkg::DATA_W-1:0] rx_data,
    output logic                        rx_frame_error,  // sticky
    output logic                        rx_overrun,      // sticky
    input  logic                        status_clear
);

    logic                        tx_pop;
    logic [uart_pkg::DATA_W-1:0] tx_head;

    logic                        rx_push;      // from the receive engine
    logic [uart_pkg::DATA_W-1:0] rx_byte;
    logic                        rx_push_ok;   // push gated with not-full
    logic                        rx_full;
    logic                        rx_empty;
    logic                        rx_frame_bad;

    baud_if tx_bif ();
    baud_if rx_bif ();

    // both timers run off the same runtime divisor
    assign tx_bif.baud_div = baud_div;
    assign rx_bif.baud_div = baud_div;

    byte_fifo u_tx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (tx_write),   // dropped inside the queue when full
        .wr_data (tx_data),
        .pop     (tx_pop),
        .rd_data (tx_head),
        .full    (tx_full),
        .empty   (tx_empty)
    );

    baud_timer u_tx_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .bif   (tx_bif)
    );

    uart_tx_fsm u_tx_fsm (
        .clk     (clk),
        .rst_n   (rst_n),
        .empty   (tx_empty),
        .rd_data (tx_head),
        .pop     (tx_pop),
        .tx_pin  (tx_pin),
        .bif     (tx_bif)
    );

    // separate timer, its phase follows the received start edge
    baud_timer u_rx_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .bif   (rx_bif)
    );

    uart_rx_fsm u_rx_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_pin      (rx_pin),
        .push        (rx_push),
        .wr_data     (rx_byte),
        .frame_error (rx_frame_bad),
        .bif         (rx_bif)
    );

    assign rx_push_ok = rx_push && !rx_full;

    byte_fifo u_rx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (rx_push_ok),
        .wr_data (rx_byte),
        .pop     (rx_read),
        .rd_data (rx_data),
        .full    (rx_full),
        .empty   (rx_empty)
    );

    assign rx_ready = !rx_empty;

    // sticky flags, a new event in the clear cycle still sets the flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_frame_error <= 1'b0;
            rx_overrun <= 1'b0;
        end else begin
            rx_frame_error <= rx_frame_bad || (rx_frame_error && !status_clear);
            rx_overrun <= (rx_push && rx_full) || (rx_overrun && !status_clear);
        end
    end

endmodule

// ==== tests/uart_assertions.sv ====
module uart_assertions (
    input logic                clk,
    input logic                rst_n,
    input logic                tx_full,
    input logic                tx_empty,
    input logic                tx_pin,
    input uart_pkg::tx_state_t tx_state,  // serializer state from inside the DUT
    input logic                rx_ready,
    input logic                rx_read
);

    int fail_count = 0;  // assertion failures seen so far

    // a queue level cannot be full and empty at once
    tx_flags_consistent: assert property (@(posedge clk) disable iff (!rst_n)
        !(tx_full && tx_empty))
    else begin
        fail_count++;
        $error("tx_full and tx_empty are high together");
    end

    // idle serializer keeps the line marking
    tx_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_state == uart_pkg::TX_IDLE) |-> tx_pin)
    else begin
        fail_count++;
        $error("tx_pin is low while the transmit engine is idle");
    end

    // only a read pops the receive queue
    rx_ready_falls_on_read: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(rx_ready) |-> $past(rx_read))
    else begin
        fail_count++;
        $error("rx_ready fell without a preceding read");
    end

endmodule

bind uart_top uart_assertions asrt_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_full  (tx_full),
    .tx_empty (tx_empty),
    .tx_pin   (tx_pin),
    .tx_state (u_tx_fsm.state),
    .rx_ready (rx_ready),
    .rx_read  (rx_read)
);

// ==== tests/tb_uart.sv ====
module tb_uart;

    localparam int BIT_CYC = 8;                 // baud divisor for every test
    localparam int FRAME_CYC = 10 * BIT_CYC;    // start, 8 data, stop
    localparam int NUM_FRAMES = 47;             // 1 + 17 + 10 + 2 + 17 frames over all tests
    // every frame plus a gap of two bits, and slack for reset and reads
    localparam int MAX_CYCLES = NUM_FRAMES * (FRAME_CYC + 2 * BIT_CYC) + 1000;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic [uart_pkg::DIV_W-1:0]  baud_div;
    logic                        tx_write;
    logic [uart_pkg::DATA_W-1:0] tx_data;
    logic                        tx_pin;
    logic                        tx_full;
    logic                        tx_empty;
    logic                        rx_pin;
    logic                        rx_read;
    logic                        rx_ready;
    logic [uart_pkg::DATA_W-1:0] rx_data;
    logic                        rx_frame_error;
    logic                        rx_overrun;
    logic                        status_clear;
    logic                        loopback;  // rx_pin follows tx_pin when set
    logic                        line_drv;  // line level driven by the testbench

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    assign rx_pin = loopback ? tx_pin : line_drv;

    uart_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .baud_div       (baud_div),
        .tx_write       (tx_write),
        .tx_data        (tx_data),
        .tx_pin         (tx_pin),
        .tx_full        (tx_full),
        .tx_empty       (tx_empty),
        .rx_pin         (rx_pin),
        .rx_read        (rx_read),
        .rx_ready       (rx_ready),
        .rx_data        (rx_data),
        .rx_frame_error (rx_frame_error),
        .rx_overrun     (rx_overrun),
        .status_clear   (status_clear)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // advance to just after the next rising edge where inputs change
    task automatic step(input int n = 1);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic write_byte(input logic [7:0] b);
        tx_write = 1'b1;
        tx_data = b;
        step();
        tx_write = 1'b0;
    endtask

    // follow one frame on tx_pin with each bit sampled in the middle of its period
    task automatic check_tx_frame(input string name, input logic [7:0] exp);
        int         wait_cyc;
        logic [7:0] got;
        wait_cyc = 0;
        while (tx_pin !== 1'b0 && wait_cyc < 4 * FRAME_CYC) begin
            step();
            wait_cyc++;
        end
        if (tx_pin !== 1'b0) begin
            $display("%s: no start bit appeared on tx_pin", name);
            errors++;
        end else begin
            step(BIT_CYC / 2);  // middle of the start bit
            checks += 3;
            if (tx_pin !== 1'b0) begin
                $display("Mismatch in %s: start bit expected 0, actual %b", name, tx_pin);
                errors++;
            end
            for (int i = 0; i < 8; i++) begin
                step(BIT_CYC);
                got[i] = tx_pin;  // lsb first
            end
            step(BIT_CYC);
            if (tx_pin !== 1'b1) begin
                $display("Mismatch in %s: stop bit expected 1, actual %b", name, tx_pin);
                errors++;
            end
            if (got !== exp) begin
                $display("Mismatch in %s: line byte expected %h, actual %h", name, exp, got);
                errors++;
            end
        end
    endtask

    // wait for a received byte then compare the head and pop it
    task automatic read_expect(input string name, input logic [7:0] exp);
        int wait_cyc;
        wait_cyc = 0;
        while (!rx_ready && wait_cyc < 2 * FRAME_CYC) begin
            step();
            wait_cyc++;
        end
        checks++;
        if (!rx_ready) begin
            $display("%s: rx_ready never rose while a byte was expected", name);
            errors++;
        end else begin
            if (rx_data !== exp) begin
                $display("Mismatch in %s: rx_data expected %h, actual %h", name, exp, rx_data);
                errors++;
            end
            rx_read = 1'b1;
            step();
            rx_read = 1'b0;
        end
    endtask

    // drive one frame on line_drv followed by an idle bit
    task automatic send_frame(input logic [7:0] b, input logic stop_bit);
        line_drv = 1'b0;
        step(BIT_CYC);
        for (int i = 0; i < 8; i++) begin
            line_drv = b[i];
            step(BIT_CYC);
        end
        line_drv = stop_bit;
        step(BIT_CYC);
        line_drv = 1'b1;
        step(BIT_CYC);
    endtask

    task automatic test_reset_state();
        checks++;
        if ({tx_pin, tx_empty, tx_full, rx_ready, rx_frame_error, rx_overrun} !== 6'b110000) begin
            $display("Mismatch in reset_state: flags expected 110000, actual %b",
                     {tx_pin, tx_empty, tx_full, rx_ready, rx_frame_error, rx_overrun});
            errors++;
        end
    endtask

    task automatic test_single_loopback();
        loopback = 1'b1;
        write_byte(8'hA5);
        check_tx_frame("single_loopback", 8'hA5);
        read_expect("single_loopback", 8'hA5);
        checks++;
        if (rx_ready !== 1'b0) begin
            $display("Mismatch in single_loopback: rx_ready expected 0, actual %b", rx_ready);
            errors++;
        end
    endtask

    // the first write goes straight to the serializer, so the queue fills on write 17
    task automatic test_tx_fill();
        logic [7:0] bytes [18];
        loopback = 1'b0;
        for (int i = 0; i < 18; i++) begin
            bytes[i] = 8'(i * 8'h11) ^ 8'h3C;
        end
        fork
            begin
                for (int i = 0; i < 18; i++) begin
                    write_byte(bytes[i]);
                    if (i == 15 && tx_full !== 1'b0) begin
                        $display("Mismatch in tx_fill: tx_full expected 0, actual %b", tx_full);
                        errors++;
                    end
                    if (i >= 16 && tx_full !== 1'b1) begin
                        $display("Mismatch in tx_fill: tx_full expected 1, actual %b", tx_full);
                        errors++;
                    end
                end
            end
            begin
                for (int k = 0; k < 17; k++) begin
                    check_tx_frame("tx_fill", bytes[k]);  // byte 18 must never appear
                end
            end
        join
        checks += 4;
        if (tx_empty !== 1'b1) begin
            $display("Mismatch in tx_fill: tx_empty expected 1, actual %b", tx_empty);
            errors++;
        end
    endtask

    task automatic test_random_burst();
        logic [7:0] sent [$];
        logic [7:0] b;
        loopback = 1'b1;
        for (int i = 0; i < 10; i++) begin
            b = 8'($urandom);
            sent.push_back(b);
            write_byte(b);
        end
        while (sent.size() > 0) begin
            read_expect("random_burst", sent.pop_front());
        end
    endtask

    task automatic test_framing_error();
        loopback = 1'b0;
        send_frame(8'h3C, 1'b0);  // stop bit held low
        checks += 2;
        if (rx_frame_error !== 1'b1 || rx_ready !== 1'b0) begin
            $display("Mismatch in framing_error: error,ready expected 10, actual %b%b",
                     rx_frame_error, rx_ready);
            errors++;
        end
        status_clear = 1'b1;
        step();
        status_clear = 1'b0;
        if (rx_frame_error !== 1'b0) begin
            $display("Mismatch in framing_error: flag after clear expected 0, actual %b",
                     rx_frame_error);
            errors++;
        end
        send_frame(8'hC3, 1'b1);
        read_expect("framing_error", 8'hC3);
    endtask

    task automatic test_overrun();
        logic [7:0] bytes [17];
        loopback = 1'b0;
        for (int i = 0; i < 17; i++) begin
            bytes[i] = 8'(i * 37 + 5);
            send_frame(bytes[i], 1'b1);
            if (i == 15 && rx_overrun !== 1'b0) begin
                $display("Mismatch in overrun: flag after 16 frames expected 0, actual %b",
                         rx_overrun);
                errors++;
            end
        end
        checks += 3;
        if (rx_overrun !== 1'b1) begin
            $display("Mismatch in overrun: rx_overrun expected 1, actual %b", rx_overrun);
            errors++;
        end
        for (int i = 0; i < 16; i++) begin
            read_expect("overrun", bytes[i]);
        end
        if (rx_ready !== 1'b0) begin
            $display("Mismatch in overrun: rx_ready expected 0, actual %b", rx_ready);
            errors++;
        end
    endtask

    initial begin
        void'($urandom(10));
        rst_n = 1'b0;
        baud_div = uart_pkg::DIV_W'(BIT_CYC);
        tx_write = 1'b0;
        tx_data = '0;
        rx_read = 1'b0;
        status_clear = 1'b0;
        loopback = 1'b1;
        line_drv = 1'b1;
        step(8);
        rst_n = 1'b1;
        step();

        test_reset_state();
        test_single_loopback();
        test_tx_fill();
        test_random_burst();
        test_framing_error();
        test_overrun();

        errors += dut_i.asrt_i.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut_i.asrt_i.fail_count);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/uart_pkg.sv
rtl/baud_if.sv
rtl/baud_timer.sv
rtl/byte_fifo.sv
rtl/uart_tx_fsm.sv
rtl/uart_rx_fsm.sv
rtl/uart_top.sv
tests/uart_assertions.sv
tests/tb_uart.sv

// ==== Bender.yml ====
package:
  name: uart_subsystem

sources:
  - files:
      - rtl/uart_pkg.sv
      - rtl/baud_if.sv
      - rtl/baud_timer.sv
      - rtl/byte_fifo.sv
      - rtl/uart_tx_fsm.sv
      - rtl/uart_rx_fsm.sv
      - rtl/uart_top.sv
  - target: test
    files:
      - tests/uart_assertions.sv
      - tests/tb_uart.sv
